/* rowdot_top.f */
source/rowdot_pkg.sv
source/dual_port_mem_d1.sv
source/rowdot_sequencer.sv
source/mac_unit.sv
source/rowdot_top.sv
testbench/rowdot_checker.sv
testbench/tb_rowdot.sv

/* testbench/tb_rowdot.sv */
`timescale 1ns/10ps

module tb_rowdot;

  import rowdot_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_TESTS    = 6;
  localparam int LOAD_CYCLES  = 2 * ROWS * COLS;
  localparam int RUN_CYCLES   = 19;
  localparam int READ_CYCLES  = ROWS + 2;
  localparam int RUN_LIMIT    = 2 * RUN_CYCLES;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (LOAD_CYCLES + RUN_CYCLES + READ_CYCLES) * 2;
  localparam logic [31:0] SEED = 32'h6d6a_7099;

  logic                      clk;
  logic                      reset;
  logic                      load_en;
  logic                      load_sel;
  logic [MAT_ADDR_WIDTH-1:0] load_addr;
  logic [ELEM_WIDTH-1:0]     load_data;
  logic                      start;
  logic                      busy;
  logic                      done;
  logic                      res_rd_en;
  logic [ROW_ADDR_WIDTH-1:0] res_addr;
  logic [ACC_WIDTH-1:0]      res_data;
  int                        error_total;

  initial clk = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rowdot_top rowdot_top_inst (
    .clk(clk), .reset(reset),
    .load_en(load_en), .load_sel(load_sel), .load_addr(load_addr), .load_data(load_data),
    .start(start), .busy(busy), .done(done),
    .res_rd_en(res_rd_en), .res_addr(res_addr), .res_data(res_data)
  );

  rowdot_checker rowdot_checker_inst (
    .clk(clk), .reset(reset),
    .load_en(load_en), .load_sel(load_sel), .load_addr(load_addr), .load_data(load_data),
    .start(start), .busy(busy), .done(done),
    .res_rd_en(res_rd_en), .res_addr(res_addr), .res_data(res_data),
    .error_total(error_total)
  );

  // Test boundaries sit on the falling edge, away from the checker's sampling
  task automatic begin_test(input string name);
    @(negedge clk);
    rowdot_checker_inst.open_test(name);
    @(posedge clk);
  endtask

  task automatic end_test();
    @(posedge clk);
    @(negedge clk);
    rowdot_checker_inst.close_test();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
  endtask

  task automatic load_element(input bit sel, input int addr, input int value);
    load_en   <= 1'b1;
    load_sel  <= sel;
    load_addr <= addr[MAT_ADDR_WIDTH-1:0];
    load_data <= value[ELEM_WIDTH-1:0];
    @(posedge clk);
    load_en   <= 1'b0;
  endtask

  task automatic load_random_matrix(input bit sel);
    for (int i = 0; i < ROWS * COLS; i++) begin
      load_element(sel, i, $urandom_range(0, 255));
    end
  endtask

  task automatic fill_matrix(input bit sel, input int value);
    for (int i = 0; i < ROWS * COLS; i++) begin
      load_element(sel, i, value);
    end
  endtask

  // Overwrite a few B elements, A is left alone
  task automatic reload_random_b(input int count);
    for (int k = 0; k < count; k++) begin
      load_element(1'b1, $urandom_range(0, ROWS * COLS - 1), $urandom_range(0, 255));
    end
  endtask

  // Optionally pokes start again while the engine is busy
  task automatic run_and_wait(input bit poke_while_busy);
    int waited;
    bit seen;
    waited = 0;
    seen = 1'b0;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!seen && waited < RUN_LIMIT) begin
      @(posedge clk);
      waited++;
      if (poke_while_busy && waited == 5) begin
        start <= 1'b1;
      end else begin
        start <= 1'b0;
      end
      if (done) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      rowdot_checker_inst.report_failure(
        $sformatf("done did not arrive within %0d cycles of start", RUN_LIMIT));
    end
  endtask

  task automatic read_results();
    for (int r = 0; r < ROWS; r++) begin
      res_rd_en <= 1'b1;
      res_addr  <= r[ROW_ADDR_WIDTH-1:0];
      @(posedge clk);
    end
    res_rd_en <= 1'b0;
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_sel  = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    res_rd_en = 1'b0;
    res_addr  = '0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Read register is cleared by reset
    begin_test("reset_state");
    idle(4);
    end_test();

    begin_test("random_run");
    load_random_matrix(1'b0);
    load_random_matrix(1'b1);
    run_and_wait(1'b0);
    read_results();
    end_test();

    begin_test("fixed_latency");
    run_and_wait(1'b1);
    idle(RUN_CYCLES + 4);
    read_results();
    end_test();

    begin_test("partial_reload");
    reload_random_b(5);
    run_and_wait(1'b0);
    read_results();
    end_test();

    begin_test("extremes");
    fill_matrix(1'b0, 255);
    fill_matrix(1'b1, 255);
    run_and_wait(1'b0);
    read_results();
    fill_matrix(1'b0, 0);
    run_and_wait(1'b0);
    read_results();
    end_test();

    // res_data must hold the last row read across idle time and a run
    begin_test("read_hold");
    load_random_matrix(1'b0);
    run_and_wait(1'b0);
    read_results();
    idle(6);
    load_random_matrix(1'b0);
    run_and_wait(1'b0);
    idle(6);
    read_results();
    end_test();

    rowdot_checker_inst.print_summary();
    if (error_total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* testbench/rowdot_checker.sv */
`timescale 1ns/10ps

module rowdot_checker (
  input  wire logic                                  clk,
  input  wire logic                                  reset,

  // Load port, mirrored into the shadow matrices
  input  wire logic                                  load_en,
  input  wire logic                                  load_sel,
  input  wire logic [rowdot_pkg::MAT_ADDR_WIDTH-1:0] load_addr,
  input  wire logic [rowdot_pkg::ELEM_WIDTH-1:0]     load_data,

  // Run control
  input  wire logic                                  start,
  input  wire logic                                  busy,
  input  wire logic                                  done,

  // Result readback
  input  wire logic                                  res_rd_en,
  input  wire logic [rowdot_pkg::ROW_ADDR_WIDTH-1:0] res_addr,
  input  wire logic [rowdot_pkg::ACC_WIDTH-1:0]      res_data,

  output int                                         error_total
);

  import rowdot_pkg::*;

  // Cycles from the start edge to the done pulse
  localparam int RUN_CYCLES = 19;

  logic [ELEM_WIDTH-1:0] a_shadow [ROWS * COLS];
  logic [ELEM_WIDTH-1:0] b_shadow [ROWS * COLS];
  logic [ACC_WIDTH-1:0]  res_model [ROWS];
  logic [ACC_WIDTH-1:0]  pending [ROWS];
  logic [ACC_WIDTH-1:0]  read_model;

  bit    in_run;
  bit    was_busy;
  int    run_cycle;
  string test_name = "none";
  int    test_errors;
  int    test_checks;
  int    tests_run;
  int    tests_failed;
  int    check_count;

  initial begin
    error_total = 0;
    test_errors = 0;
    test_checks = 0;
    tests_run = 0;
    tests_failed = 0;
    check_count = 0;
    for (int r = 0; r < ROWS; r++) begin
      res_model[r] = '0;
      pending[r] = '0;
    end
  end

  // Row dot product of the shadow matrices
  function automatic logic [ACC_WIDTH-1:0] row_sum(input int r);
    int total;
    total = 0;
    for (int c = 0; c < COLS; c++) begin
      total = total + int'(a_shadow[r * COLS + c]) * int'(b_shadow[r * COLS + c]);
    end
    return total;
  endfunction

  task automatic compare(input string what, input logic [ACC_WIDTH-1:0] expected,
                         input logic [ACC_WIDTH-1:0] actual);
    check_count++;
    test_checks++;
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
      test_errors++;
      error_total++;
    end
  endtask

  task report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    test_errors++;
    error_total++;
  endtask

  task open_test(input string name);
    test_name = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task close_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok, %0d checks", test_name, test_checks);
    end else begin
      tests_failed++;
      $display("test %s: FAILED, %0d errors in %0d checks", test_name, test_errors, test_checks);
    end
  endtask

  task print_summary();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_total);
  endtask

  // Outputs seen here belong to the cycle that just ended
  always @(posedge clk) begin
    if (reset) begin
      read_model = '0;
      in_run = 1'b0;
      run_cycle = 0;
    end else begin
      compare("res_data", read_model, res_data);
      was_busy = in_run;
      if (in_run) begin
        run_cycle++;
        compare($sformatf("busy in run cycle %0d", run_cycle), 1, busy);
        compare($sformatf("done in run cycle %0d", run_cycle), run_cycle == RUN_CYCLES, done);
        if (run_cycle == RUN_CYCLES) begin
          for (int r = 0; r < ROWS; r++) begin
            res_model[r] = pending[r];
          end
          in_run = 1'b0;
        end
      end else begin
        compare("busy while idle", 0, busy);
        compare("done while idle", 0, done);
      end

      // Start is taken only when the engine was idle
      if (start && !was_busy) begin
        for (int r = 0; r < ROWS; r++) begin
          pending[r] = row_sum(r);
        end
        in_run = 1'b1;
        run_cycle = 0;
      end

      if (load_en) begin
        if (load_sel) begin
          b_shadow[load_addr] = load_data;
        end else begin
          a_shadow[load_addr] = load_data;
        end
      end

      if (res_rd_en) begin
        read_model = res_model[res_addr];
      end
    end
  end

endmodule

/* source/rowdot_top.sv */
`timescale 1ns/10ps

module rowdot_top (
  input  wire logic                                clk,
  input  wire logic                                reset,

  // Matrix load, sel 0 is A and 1 is B
  input  wire logic                                load_en,
  input  wire logic                                load_sel,
  input  wire logic [rowdot_pkg::MAT_ADDR_WIDTH-1:0] load_addr,
  input  wire logic [rowdot_pkg::ELEM_WIDTH-1:0]     load_data,

  // Run control
  input  wire logic                                start,
  output logic                                     busy,
  output logic                                     done,

  // Result readback
  input  wire logic                                res_rd_en,
  input  wire logic [rowdot_pkg::ROW_ADDR_WIDTH-1:0] res_addr,
  output logic      [rowdot_pkg::ACC_WIDTH-1:0]      res_data
);

  import rowdot_pkg::*;

  logic                      a_we;
  logic                      b_we;
  logic                      rd_en;
  logic [MAT_ADDR_WIDTH-1:0] rd_addr;
  logic [ELEM_WIDTH-1:0]     a_data;
  logic [ELEM_WIDTH-1:0]     b_data;
  logic                      data_valid;
  logic                      first;
  logic                      last;
  logic [ROW_ADDR_WIDTH-1:0] row;
  logic [ACC_WIDTH-1:0]      sum;
  logic                      sum_valid;
  logic [ROW_ADDR_WIDTH-1:0] sum_row;

  assign a_we = load_en & ~load_sel;
  assign b_we = load_en & load_sel;

  dual_port_mem_d1 #(.WIDTH(ELEM_WIDTH), .SIZE(ROWS * COLS)) mem_a (
    .clk(clk), .reset(reset),
    .read_en(rd_en), .addr0_r(rd_addr), .read_data(a_data),
    .write_en(a_we), .write_data(load_data), .addr0_w(load_addr)
  );

  dual_port_mem_d1 #(.WIDTH(ELEM_WIDTH), .SIZE(ROWS * COLS)) mem_b (
    .clk(clk), .reset(reset),
    .read_en(rd_en), .addr0_r(rd_addr), .read_data(b_data),
    .write_en(b_we), .write_data(load_data), .addr0_w(load_addr)
  );

  rowdot_sequencer rowdot_sequencer_inst (
    .clk(clk), .reset(reset),
    .start(start), .busy(busy), .done(done),
    .rd_en(rd_en), .rd_addr(rd_addr),
    .data_valid(data_valid), .first(first), .last(last), .row(row),
    .sum_valid(sum_valid)
  );

  mac_unit mac_unit_inst (
    .clk(clk), .reset(reset),
    .a_data(a_data), .b_data(b_data),
    .data_valid(data_valid), .first(first), .last(last), .row(row),
    .sum(sum), .sum_valid(sum_valid), .sum_row(sum_row)
  );

  // Row sums land here, host reads them back
  dual_port_mem_d1 #(.WIDTH(ACC_WIDTH), .SIZE(ROWS)) mem_result (
    .clk(clk), .reset(reset),
    .read_en(res_rd_en), .addr0_r(res_addr), .read_data(res_data),
    .write_en(sum_valid), .write_data(sum), .addr0_w(sum_row)
  );

endmodule

/* source/mac_unit.sv */
`timescale 1ns/10ps

module mac_unit (
  input  wire logic                                clk,
  input  wire logic                                reset,

  // Operand streams from the A and B memories
  input  wire logic [rowdot_pkg::ELEM_WIDTH-1:0]     a_data,
  input  wire logic [rowdot_pkg::ELEM_WIDTH-1:0]     b_data,

  // Beat tags from the sequencer
  input  wire logic                                data_valid,
  input  wire logic                                first,
  input  wire logic                                last,
  input  wire logic [rowdot_pkg::ROW_ADDR_WIDTH-1:0] row,

  // Result write
  output logic      [rowdot_pkg::ACC_WIDTH-1:0]      sum,
  output logic                                     sum_valid,
  output logic      [rowdot_pkg::ROW_ADDR_WIDTH-1:0] sum_row
);

  import rowdot_pkg::*;

  logic [2*ELEM_WIDTH-1:0] prod;
  logic [ACC_WIDTH-1:0]    prod_ext;
  logic [ACC_WIDTH-1:0]    acc;
  logic [ACC_WIDTH-1:0]    acc_next;

  assign prod     = a_data * b_data;
  assign prod_ext = ACC_WIDTH'(prod);

  // First beat of a row restarts the sum
  assign acc_next = first ? prod_ext : acc + prod_ext;

  always_ff @(posedge clk) begin
    if (data_valid) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= data_valid && last;
    end
  end

  // Completed sum and its row, held for the result write
  always_ff @(posedge clk) begin
    if (data_valid && last) begin
      sum     <= acc_next;
      sum_row <= row;
    end
  end

endmodule

/* source/rowdot_sequencer.sv */
`timescale 1ns/10ps

module rowdot_sequencer (
  input  wire logic                                clk,
  input  wire logic                                reset,

  // Host control
  input  wire logic                                start,
  output logic                                     busy,
  output logic                                     done,

  // Paired reads to A and B
  output logic                                     rd_en,
  output logic      [rowdot_pkg::MAT_ADDR_WIDTH-1:0] rd_addr,

  // Beat tags, aligned with the returning read data
  output logic                                     data_valid,
  output logic                                     first,
  output logic                                     last,
  output logic      [rowdot_pkg::ROW_ADDR_WIDTH-1:0] row,

  // Completed row sums from the MAC unit
  input  wire logic                                sum_valid
);

  import rowdot_pkg::*;

  localparam int COL_WIDTH = MAT_ADDR_WIDTH - ROW_ADDR_WIDTH;

  seq_state_t state;
  seq_state_t state_next;

  logic [ROW_ADDR_WIDTH-1:0] rows_done;
  logic [COL_WIDTH-1:0]      col;
  logic                      addr_last;
  logic                      row_last;

  assign col       = rd_addr[COL_WIDTH-1:0];
  assign addr_last = (rd_addr == MAT_ADDR_WIDTH'(ROWS * COLS - 1));
  assign row_last  = (rows_done == ROW_ADDR_WIDTH'(ROWS - 1));

  assign rd_en = (state == READ);
  assign busy  = (state != IDLE);
  assign done  = (state == FINISH);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_next = READ;
        end
      end
      READ: begin
        if (addr_last) begin
          state_next = DRAIN;
        end
      end
      // Wait for the last row sum to be written
      DRAIN: begin
        if (sum_valid && row_last) begin
          state_next = FINISH;
        end
      end
      FINISH: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Flat read address and finished-row count
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr   <= '0;
      rows_done <= '0;
    end else if (state == IDLE) begin
      rd_addr   <= '0;
      rows_done <= '0;
    end else begin
      if (rd_en) begin
        rd_addr <= rd_addr + 1'b1;
      end
      if (sum_valid) begin
        rows_done <= rows_done + 1'b1;
      end
    end
  end

  // Tags delayed by the memory read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    first <= (col == '0);
    last  <= (col == COL_WIDTH'(COLS - 1));
    row   <= rd_addr[MAT_ADDR_WIDTH-1 -: ROW_ADDR_WIDTH];
  end

endmodule

/* source/dual_port_mem_d1.sv */
`timescale 1ns/10ps

module dual_port_mem_d1 #(
  parameter int WIDTH = 32,
  parameter int SIZE  = 16
) (
  input  wire logic                    clk,
  input  wire logic                    reset,

  // Read port, one cycle latency
  input  wire logic                    read_en,
  input  wire logic [$clog2(SIZE)-1:0] addr0_r,
  output logic      [WIDTH-1:0]        read_data,

  // Write port
  input  wire logic                    write_en,
  input  wire logic [WIDTH-1:0]        write_data,
  input  wire logic [$clog2(SIZE)-1:0] addr0_w
);

  logic [WIDTH-1:0] mem [SIZE];
  logic [WIDTH-1:0] read_out;

  assign read_data = read_out;

  // Holds last value when read_en is low
  always_ff @(posedge clk) begin
    if (reset) begin
      read_out <= '0;
    end else if (read_en) begin
      read_out <= mem[addr0_r];
    end
  end

  // Same-address read in this cycle sees the old word
  always_ff @(posedge clk) begin
    if (!reset && write_en) begin
      mem[addr0_w] <= write_data;
    end
  end

endmodule

/* source/rowdot_pkg.sv */
package rowdot_pkg;

  // Matrix dimensions
  localparam int ROWS = 4;
  localparam int COLS = 4;

  // Data widths
  localparam int ELEM_WIDTH = 8;
  localparam int ACC_WIDTH  = 32;

  // Flat matrix address is row * COLS + column
  localparam int MAT_ADDR_WIDTH = $clog2(ROWS * COLS);

  // Row index, also the result memory address
  localparam int ROW_ADDR_WIDTH = $clog2(ROWS);

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    READ   = 2'd1,
    DRAIN  = 2'd2,
    FINISH = 2'd3
  } seq_state_t;

endpackage
